// File: common/rvCorePkg.sv
package rvCorePkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  regIndex_t;

    typedef enum logic [3:0] {
        AluAdd,
        AluSub,
        AluAnd,
        AluOr,
        AluXor,
        AluSlt,
        AluSll,
        AluSrl
    } aluOp_t;

    // Major opcodes of the supported subset
    localparam logic [6:0] OpReg    = 7'b0110011;
    localparam logic [6:0] OpImm    = 7'b0010011;
    localparam logic [6:0] OpLoad   = 7'b0000011;
    localparam logic [6:0] OpStore  = 7'b0100011;
    localparam logic [6:0] OpBranch = 7'b1100011;

    // Branch conditions in funct3
    localparam logic [2:0] F3Beq = 3'b000;
    localparam logic [2:0] F3Bne = 3'b001;
    localparam logic [2:0] F3Blt = 3'b100;
    localparam logic [2:0] F3Bge = 3'b101;

    typedef struct packed {
        logic [6:0] funct7;
        regIndex_t  rs2;
        regIndex_t  rs1;
        logic [2:0] funct3;
        regIndex_t  rd;
        logic [6:0] opcode;
    } rFormat_t;

    typedef struct packed {
        logic [11:0] imm12;
        regIndex_t   rs1;
        logic [2:0]  funct3;
        regIndex_t   rd;
        logic [6:0]  opcode;
    } iFormat_t;

    typedef struct packed {
        logic [6:0] immHi;
        regIndex_t  rs2;
        regIndex_t  rs1;
        logic [2:0] funct3;
        logic [4:0] immLo;
        logic [6:0] opcode;
    } sFormat_t;

    typedef struct packed {
        logic       immSign;  // imm[12]
        logic [5:0] immMid;   // imm[10:5]
        regIndex_t  rs2;
        regIndex_t  rs1;
        logic [2:0] funct3;
        logic [3:0] immLow;   // imm[4:1]
        logic       immBit11; // imm[11]
        logic [6:0] opcode;
    } bFormat_t;

    // One instruction word, four ways of reading it
    typedef union packed {
        rFormat_t r;
        iFormat_t i;
        sFormat_t s;
        bFormat_t b;
    } instrWord_t;

endpackage

// File: decode/regFile.sv
`timescale 1ns/1ps

module regFile (
    input  logic                clk,
    input  logic                reset,
    input  rvCorePkg::regIndex_t rs1Addr,
    input  rvCorePkg::regIndex_t rs2Addr,
    input  logic                writeEnable,
    input  rvCorePkg::regIndex_t writeAddr,
    input  rvCorePkg::word_t     writeData,
    output rvCorePkg::word_t     rs1Val,
    output rvCorePkg::word_t     rs2Val
);
    import rvCorePkg::*;

    word_t regs [32];

    // Writes to x0 are dropped
    always_ff @(posedge clk) begin
        if (!reset && writeEnable && writeAddr != '0) begin
            regs[writeAddr] <= writeData;
        end
    end

    // x0 is hardwired to zero
    assign rs1Val = (rs1Addr == '0) ? '0 : regs[rs1Addr];
    assign rs2Val = (rs2Addr == '0) ? '0 : regs[rs2Addr];

endmodule

// File: decode/decoder.sv
`timescale 1ns/1ps

module decoder (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 instrValid,
    input  rvCorePkg::instrWord_t instr,
    input  rvCorePkg::word_t      pc,
    input  rvCorePkg::word_t      rs1Val,
    input  rvCorePkg::word_t      rs2Val,
    input  logic                 fwdExecValid,
    input  rvCorePkg::regIndex_t  fwdExecAddr,
    input  rvCorePkg::word_t      fwdExecData,
    input  logic                 fwdWbValid,
    input  rvCorePkg::regIndex_t  fwdWbAddr,
    input  rvCorePkg::word_t      fwdWbData,
    output rvCorePkg::regIndex_t  rs1Addr,
    output rvCorePkg::regIndex_t  rs2Addr,
    output logic                 dValid,
    output logic                 dIllegal,
    output rvCorePkg::aluOp_t     dAluOp,
    output logic                 dAluSrc,
    output logic                 dBranch,
    output logic [2:0]           dFunct3,
    output logic                 dMemRead,
    output logic                 dMemWrite,
    output logic                 dRegWrite,
    output rvCorePkg::regIndex_t  dRd,
    output rvCorePkg::word_t      dRs1Val,
    output rvCorePkg::word_t      dRs2Val,
    output rvCorePkg::word_t      dImm,
    output rvCorePkg::word_t      dPc
);
    import rvCorePkg::*;

    logic   illegal, aluSrc, branch, memRead, memWrite, regWrite;
    aluOp_t aluOp;
    word_t  imm;
    word_t  rs1Fwd, rs2Fwd;

    assign rs1Addr = instr.r.rs1;
    assign rs2Addr = instr.r.rs2;

    always_comb begin
        illegal  = 1'b1; // Cleared by each legal encoding
        aluOp    = AluAdd;
        aluSrc   = 1'b0;
        branch   = 1'b0;
        memRead  = 1'b0;
        memWrite = 1'b0;
        regWrite = 1'b0;
        imm      = {{20{instr.i.imm12[11]}}, instr.i.imm12};
        case (instr.r.opcode)
            OpReg: begin
                illegal  = 1'b0;
                regWrite = 1'b1;
                case ({instr.r.funct7, instr.r.funct3})
                    10'b0000000_000: aluOp = AluAdd;
                    10'b0100000_000: aluOp = AluSub;
                    10'b0000000_111: aluOp = AluAnd;
                    10'b0000000_110: aluOp = AluOr;
                    10'b0000000_100: aluOp = AluXor;
                    10'b0000000_010: aluOp = AluSlt;
                    10'b0000000_001: aluOp = AluSll;
                    10'b0000000_101: aluOp = AluSrl;
                    default: begin
                        illegal  = 1'b1;
                        regWrite = 1'b0;
                    end
                endcase
            end
            OpImm: begin
                illegal  = 1'b0;
                regWrite = 1'b1;
                aluSrc   = 1'b1;
                case (instr.i.funct3)
                    3'b000:  aluOp = AluAdd;
                    3'b111:  aluOp = AluAnd;
                    3'b110:  aluOp = AluOr;
                    3'b100:  aluOp = AluXor;
                    3'b010:  aluOp = AluSlt;
                    default: begin
                        illegal  = 1'b1;
                        regWrite = 1'b0;
                    end
                endcase
            end
            OpLoad: begin
                if (instr.i.funct3 == 3'b010) begin // lw only
                    illegal  = 1'b0;
                    aluSrc   = 1'b1;
                    memRead  = 1'b1;
                    regWrite = 1'b1;
                end
            end
            OpStore: begin
                imm = {{20{instr.s.immHi[6]}}, instr.s.immHi, instr.s.immLo};
                if (instr.s.funct3 == 3'b010) begin // sw only
                    illegal  = 1'b0;
                    aluSrc   = 1'b1;
                    memWrite = 1'b1;
                end
            end
            OpBranch: begin
                imm = {{19{instr.b.immSign}}, instr.b.immSign, instr.b.immBit11,
                       instr.b.immMid, instr.b.immLow, 1'b0};
                aluOp = AluSub; // Zero result flags equality
                if (instr.b.funct3 inside {F3Beq, F3Bne, F3Blt, F3Bge}) begin
                    illegal = 1'b0;
                    branch  = 1'b1;
                end
            end
            default: ;
        endcase
    end

    // Newest producer wins, x0 always comes from the register file
    assign rs1Fwd = (rs1Addr == '0) ? rs1Val :
                    (fwdExecValid && fwdExecAddr == rs1Addr) ? fwdExecData :
                    (fwdWbValid && fwdWbAddr == rs1Addr) ? fwdWbData : rs1Val;
    assign rs2Fwd = (rs2Addr == '0) ? rs2Val :
                    (fwdExecValid && fwdExecAddr == rs2Addr) ? fwdExecData :
                    (fwdWbValid && fwdWbAddr == rs2Addr) ? fwdWbData : rs2Val;

    always_ff @(posedge clk) begin
        if (reset) begin
            dValid    <= 1'b0;
            dIllegal  <= 1'b0;
            dBranch   <= 1'b0;
            dMemRead  <= 1'b0;
            dMemWrite <= 1'b0;
            dRegWrite <= 1'b0;
        end else begin
            dValid    <= instrValid;
            dIllegal  <= instrValid & illegal;
            dBranch   <= instrValid & branch;
            dMemRead  <= instrValid & memRead;
            dMemWrite <= instrValid & memWrite;
            dRegWrite <= instrValid & regWrite;
        end
    end

    always_ff @(posedge clk) begin
        dAluOp  <= aluOp;
        dAluSrc <= aluSrc;
        dFunct3 <= instr.r.funct3;
        dRd     <= instr.r.rd;
        dRs1Val <= rs1Fwd;
        dRs2Val <= rs2Fwd;
        dImm    <= imm;
        dPc     <= pc;
    end

endmodule

// File: execute/alu.sv
`timescale 1ns/1ps

module alu (
    input  rvCorePkg::aluOp_t aluOp,
    input  rvCorePkg::word_t  opA,
    input  rvCorePkg::word_t  opB,
    output rvCorePkg::word_t  result
);
    import rvCorePkg::*;

    logic [4:0] shamt;

    assign shamt = opB[4:0]; // Only the low five bits shift

    always_comb begin
        case (aluOp)
            AluAdd:  result = opA + opB;
            AluSub:  result = opA - opB;
            AluAnd:  result = opA & opB;
            AluOr:   result = opA | opB;
            AluXor:  result = opA ^ opB;
            AluSlt:  result = {31'b0, $signed(opA) < $signed(opB)};
            AluSll:  result = opA << shamt;
            AluSrl:  result = opA >> shamt;
            default: result = '0;
        endcase
    end

endmodule

// File: execute/executeStage.sv
`timescale 1ns/1ps

module executeStage (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 dValid,
    input  logic                 dIllegal,
    input  rvCorePkg::aluOp_t     dAluOp,
    input  logic                 dAluSrc,
    input  logic                 dBranch,
    input  logic [2:0]           dFunct3,
    input  logic                 dMemRead,
    input  logic                 dMemWrite,
    input  logic                 dRegWrite,
    input  rvCorePkg::regIndex_t  dRd,
    input  rvCorePkg::word_t      dRs1Val,
    input  rvCorePkg::word_t      dRs2Val,
    input  rvCorePkg::word_t      dImm,
    input  rvCorePkg::word_t      dPc,
    output logic                 fwdExecValid,
    output rvCorePkg::regIndex_t  fwdExecAddr,
    output rvCorePkg::word_t      fwdExecData,
    output logic                 eValid,
    output logic                 eIllegal,
    output logic                 eRegWrite,
    output logic                 eMemRead,
    output logic                 eMemWrite,
    output rvCorePkg::regIndex_t  eRd,
    output rvCorePkg::word_t      eAluResult,
    output rvCorePkg::word_t      eStoreData,
    output logic                 eBranch,
    output logic                 eTaken,
    output rvCorePkg::word_t      eTarget
);
    import rvCorePkg::*;

    word_t opB, aluResult;
    logic  isEqual, isLess, taken;

    assign opB = dAluSrc ? dImm : dRs2Val;

    alu aluInst (
        .aluOp  (dAluOp),
        .opA    (dRs1Val),
        .opB    (opB),
        .result (aluResult)
    );

    // Branches run the ALU as a subtract
    assign isEqual = (aluResult == '0);
    assign isLess  = $signed(dRs1Val) < $signed(dRs2Val);

    always_comb begin
        case (dFunct3)
            F3Beq:   taken = isEqual;
            F3Bne:   taken = !isEqual;
            F3Blt:   taken = isLess;
            F3Bge:   taken = !isLess;
            default: taken = 1'b0;
        endcase
    end

    // Load data is not ready until the result stage
    assign fwdExecValid = dRegWrite & ~dMemRead;
    assign fwdExecAddr  = dRd;
    assign fwdExecData  = aluResult;

    always_ff @(posedge clk) begin
        if (reset) begin
            eValid    <= 1'b0;
            eIllegal  <= 1'b0;
            eRegWrite <= 1'b0;
            eMemRead  <= 1'b0;
            eMemWrite <= 1'b0;
            eBranch   <= 1'b0;
            eTaken    <= 1'b0;
        end else begin
            eValid    <= dValid;
            eIllegal  <= dIllegal;
            eRegWrite <= dRegWrite;
            eMemRead  <= dMemRead;
            eMemWrite <= dMemWrite;
            eBranch   <= dBranch;
            eTaken    <= dBranch & taken;
        end
    end

    always_ff @(posedge clk) begin
        eRd        <= dRd;
        eAluResult <= aluResult; // Also the memory address
        eStoreData <= dRs2Val;
        eTarget    <= dPc + dImm;
    end

endmodule

// File: result/resultStage.sv
`timescale 1ns/1ps

module resultStage #(
    parameter int memDepth = 256
) (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 eValid,
    input  logic                 eIllegal,
    input  logic                 eRegWrite,
    input  logic                 eMemRead,
    input  logic                 eMemWrite,
    input  rvCorePkg::regIndex_t  eRd,
    input  rvCorePkg::word_t      eAluResult,
    input  rvCorePkg::word_t      eStoreData,
    input  logic                 eBranch,
    input  logic                 eTaken,
    input  rvCorePkg::word_t      eTarget,
    output logic                 wbEnable,
    output rvCorePkg::regIndex_t  wbAddr,
    output rvCorePkg::word_t      wbData,
    output logic                 retireValid,
    output logic                 retireIllegal,
    output logic                 regWbEnable,
    output rvCorePkg::regIndex_t  regWbAddr,
    output rvCorePkg::word_t      regWbData,
    output logic                 branchValid,
    output logic                 branchTaken,
    output rvCorePkg::word_t      branchTarget
);
    import rvCorePkg::*;

    localparam int AddrBits = $clog2(memDepth);

    word_t                mem [memDepth];
    logic [AddrBits-1:0]  memIndex;
    word_t                loadData;

    assign memIndex = eAluResult[AddrBits+1:2]; // Word addressed
    assign loadData = mem[memIndex];

    always_ff @(posedge clk) begin
        if (eMemWrite) begin
            mem[memIndex] <= eStoreData;
        end
    end

    // Register file write port and older forwarding source
    assign wbEnable = eRegWrite;
    assign wbAddr   = eRd;
    assign wbData   = eMemRead ? loadData : eAluResult;

    always_ff @(posedge clk) begin
        if (reset) begin
            retireValid   <= 1'b0;
            retireIllegal <= 1'b0;
            regWbEnable   <= 1'b0;
            branchValid   <= 1'b0;
            branchTaken   <= 1'b0;
        end else begin
            retireValid   <= eValid;
            retireIllegal <= eIllegal;
            regWbEnable   <= wbEnable;
            branchValid   <= eBranch;
            branchTaken   <= eTaken;
        end
    end

    always_ff @(posedge clk) begin
        regWbAddr    <= wbAddr;
        regWbData    <= wbData;
        branchTarget <= eTarget;
    end

endmodule

// File: source/rvCore.sv
`timescale 1ns/1ps

module rvCore #(
    parameter int memDepth = 256
) (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 instrValid,
    input  rvCorePkg::instrWord_t instr,
    input  rvCorePkg::word_t      pc,
    output logic                 retireValid,
    output logic                 retireIllegal,
    output logic                 wbEnable,
    output rvCorePkg::regIndex_t  wbAddr,
    output rvCorePkg::word_t      wbData,
    output logic                 branchValid,
    output logic                 branchTaken,
    output rvCorePkg::word_t      branchTarget
);
    import rvCorePkg::*;

    regIndex_t rs1Addr, rs2Addr;
    word_t     rs1Val, rs2Val;

    // Decode register
    logic      dValid, dIllegal, dAluSrc, dBranch, dMemRead, dMemWrite, dRegWrite;
    aluOp_t    dAluOp;
    logic [2:0] dFunct3;
    regIndex_t dRd;
    word_t     dRs1Val, dRs2Val, dImm, dPc;

    // Execute register
    logic      eValid, eIllegal, eRegWrite, eMemRead, eMemWrite, eBranch, eTaken;
    regIndex_t eRd;
    word_t     eAluResult, eStoreData, eTarget;

    // Forwarding and write-back paths
    logic      fwdExecValid, rfWriteEnable;
    regIndex_t fwdExecAddr, rfWriteAddr;
    word_t     fwdExecData, rfWriteData;

    regFile regFileInst (
        .clk         (clk),
        .reset       (reset),
        .rs1Addr     (rs1Addr),
        .rs2Addr     (rs2Addr),
        .writeEnable (rfWriteEnable),
        .writeAddr   (rfWriteAddr),
        .writeData   (rfWriteData),
        .rs1Val      (rs1Val),
        .rs2Val      (rs2Val)
    );

    decoder decoderInst (
        .clk          (clk),
        .reset        (reset),
        .instrValid   (instrValid),
        .instr        (instr),
        .pc           (pc),
        .rs1Val       (rs1Val),
        .rs2Val       (rs2Val),
        .fwdExecValid (fwdExecValid),
        .fwdExecAddr  (fwdExecAddr),
        .fwdExecData  (fwdExecData),
        .fwdWbValid   (rfWriteEnable),
        .fwdWbAddr    (rfWriteAddr),
        .fwdWbData    (rfWriteData),
        .rs1Addr      (rs1Addr),
        .rs2Addr      (rs2Addr),
        .dValid       (dValid),
        .dIllegal     (dIllegal),
        .dAluOp       (dAluOp),
        .dAluSrc      (dAluSrc),
        .dBranch      (dBranch),
        .dFunct3      (dFunct3),
        .dMemRead     (dMemRead),
        .dMemWrite    (dMemWrite),
        .dRegWrite    (dRegWrite),
        .dRd          (dRd),
        .dRs1Val      (dRs1Val),
        .dRs2Val      (dRs2Val),
        .dImm         (dImm),
        .dPc          (dPc)
    );

    executeStage executeInst (
        .clk          (clk),
        .reset        (reset),
        .dValid       (dValid),
        .dIllegal     (dIllegal),
        .dAluOp       (dAluOp),
        .dAluSrc      (dAluSrc),
        .dBranch      (dBranch),
        .dFunct3      (dFunct3),
        .dMemRead     (dMemRead),
        .dMemWrite    (dMemWrite),
        .dRegWrite    (dRegWrite),
        .dRd          (dRd),
        .dRs1Val      (dRs1Val),
        .dRs2Val      (dRs2Val),
        .dImm         (dImm),
        .dPc          (dPc),
        .fwdExecValid (fwdExecValid),
        .fwdExecAddr  (fwdExecAddr),
        .fwdExecData  (fwdExecData),
        .eValid       (eValid),
        .eIllegal     (eIllegal),
        .eRegWrite    (eRegWrite),
        .eMemRead     (eMemRead),
        .eMemWrite    (eMemWrite),
        .eRd          (eRd),
        .eAluResult   (eAluResult),
        .eStoreData   (eStoreData),
        .eBranch      (eBranch),
        .eTaken       (eTaken),
        .eTarget      (eTarget)
    );

    resultStage #(
        .memDepth (memDepth)
    ) resultInst (
        .clk           (clk),
        .reset         (reset),
        .eValid        (eValid),
        .eIllegal      (eIllegal),
        .eRegWrite     (eRegWrite),
        .eMemRead      (eMemRead),
        .eMemWrite     (eMemWrite),
        .eRd           (eRd),
        .eAluResult    (eAluResult),
        .eStoreData    (eStoreData),
        .eBranch       (eBranch),
        .eTaken        (eTaken),
        .eTarget       (eTarget),
        .wbEnable      (rfWriteEnable),
        .wbAddr        (rfWriteAddr),
        .wbData        (rfWriteData),
        .retireValid   (retireValid),
        .retireIllegal (retireIllegal),
        .regWbEnable   (wbEnable),
        .regWbAddr     (wbAddr),
        .regWbData     (wbData),
        .branchValid   (branchValid),
        .branchTaken   (branchTaken),
        .branchTarget  (branchTarget)
    );

endmodule

// File: verif/rvCoreTb.sv
`timescale 1ns/1ps

module rvCoreTb;
    import rvCorePkg::*;

    localparam int MaxEntries = 64;
    localparam int RetireTimeout = 10; // Cycles allowed between retirements
    localparam int RunLimit = 2000;
    localparam int DrainCycles = 6;

    // funct fields of the R and I formats
    localparam logic [6:0] F7Base = 7'b0000000;
    localparam logic [6:0] F7Sub  = 7'b0100000;
    localparam logic [2:0] F3Add  = 3'b000;
    localparam logic [2:0] F3Sll  = 3'b001;
    localparam logic [2:0] F3Slt  = 3'b010;
    localparam logic [2:0] F3Xor  = 3'b100;
    localparam logic [2:0] F3Srl  = 3'b101;
    localparam logic [2:0] F3Or   = 3'b110;
    localparam logic [2:0] F3And  = 3'b111;
    localparam logic [2:0] F3Word = 3'b010;

    logic       clk;
    logic       reset;
    logic       instrValid;
    instrWord_t instr;
    word_t      pc;
    logic       retireValid, retireIllegal, wbEnable;
    regIndex_t  wbAddr;
    word_t      wbData;
    logic       branchValid, branchTaken;
    word_t      branchTarget;

    // Stimulus and expectation table
    string      names [MaxEntries];
    instrWord_t instrs [MaxEntries];
    word_t      pcs [MaxEntries];
    logic       expIllegal [MaxEntries];
    logic       expWbEn [MaxEntries];
    regIndex_t  expRd [MaxEntries];
    word_t      expData [MaxEntries];
    logic       expBranch [MaxEntries];
    logic       expTaken [MaxEntries];
    word_t      expTarget [MaxEntries];
    logic       noGapAfter [MaxEntries];
    int         numEntries;
    logic       chaining;    // Entries added now issue back to back
    int         pending [$]; // Issued but not yet retired
    logic       extraRetire; // Set by a retirement past the table end

    rvCore #(
        .memDepth (256)
    ) i_dut (
        .clk           (clk),
        .reset         (reset),
        .instrValid    (instrValid),
        .instr         (instr),
        .pc            (pc),
        .retireValid   (retireValid),
        .retireIllegal (retireIllegal),
        .wbEnable      (wbEnable),
        .wbAddr        (wbAddr),
        .wbData        (wbData),
        .branchValid   (branchValid),
        .branchTaken   (branchTaken),
        .branchTarget  (branchTarget)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic instrWord_t makeR(logic [6:0] funct7, logic [2:0] funct3,
                                         int rd, int rs1, int rs2);
        instrWord_t w;
        w.r.funct7 = funct7;
        w.r.rs2    = rs2[4:0];
        w.r.rs1    = rs1[4:0];
        w.r.funct3 = funct3;
        w.r.rd     = rd[4:0];
        w.r.opcode = OpReg;
        return w;
    endfunction

    function automatic instrWord_t makeI(logic [6:0] opcode, logic [2:0] funct3,
                                         int rd, int rs1, int imm);
        instrWord_t w;
        w.i.imm12  = imm[11:0];
        w.i.rs1    = rs1[4:0];
        w.i.funct3 = funct3;
        w.i.rd     = rd[4:0];
        w.i.opcode = opcode;
        return w;
    endfunction

    function automatic instrWord_t makeS(int rs2, int rs1, int imm);
        instrWord_t w;
        w.s.immHi  = imm[11:5];
        w.s.rs2    = rs2[4:0];
        w.s.rs1    = rs1[4:0];
        w.s.funct3 = F3Word;
        w.s.immLo  = imm[4:0];
        w.s.opcode = OpStore;
        return w;
    endfunction

    function automatic instrWord_t makeB(logic [2:0] funct3, int rs1, int rs2, int offset);
        instrWord_t  w;
        logic [12:0] imm;
        imm = offset[12:0];
        w.b.immSign  = imm[12];
        w.b.immMid   = imm[10:5];
        w.b.rs2      = rs2[4:0];
        w.b.rs1      = rs1[4:0];
        w.b.funct3   = funct3;
        w.b.immLow   = imm[4:1];
        w.b.immBit11 = imm[11];
        w.b.opcode   = OpBranch;
        return w;
    endfunction

    function automatic word_t nextPc();
        return 32'h0000_0100 + word_t'(4 * numEntries);
    endfunction

    task automatic addEntry(string name, instrWord_t word, logic illegal, logic wbEn,
                            int rd, word_t data, logic isBranch, logic taken,
                            word_t target);
        names[numEntries]      = name;
        instrs[numEntries]     = word;
        pcs[numEntries]        = nextPc();
        expIllegal[numEntries] = illegal;
        expWbEn[numEntries]    = wbEn;
        expRd[numEntries]      = rd[4:0];
        expData[numEntries]    = data;
        expBranch[numEntries]  = isBranch;
        expTaken[numEntries]   = taken;
        expTarget[numEntries]  = target;
        noGapAfter[numEntries] = chaining;
        numEntries++;
    endtask

    task automatic addWrite(string name, instrWord_t word, int rd, word_t data);
        addEntry(name, word, 1'b0, 1'b1, rd, data, 1'b0, 1'b0, '0);
    endtask

    task automatic addStore(string name, instrWord_t word);
        addEntry(name, word, 1'b0, 1'b0, 0, '0, 1'b0, 1'b0, '0);
    endtask

    task automatic addBranch(string name, instrWord_t word, logic taken, int offset);
        addEntry(name, word, 1'b0, 1'b0, 0, '0, 1'b1, taken, nextPc() + word_t'(offset));
    endtask

    task automatic addIllegal(string name, instrWord_t word);
        addEntry(name, word, 1'b1, 1'b0, 0, '0, 1'b0, 1'b0, '0);
    endtask

    task automatic buildTable();
        numEntries = 0;
        chaining   = 1'b0;
        addWrite("addi x1", makeI(OpImm, F3Add, 1, 0, 100), 1, 32'h0000_0064);
        addWrite("addi x2 neg", makeI(OpImm, F3Add, 2, 0, -7), 2, 32'hFFFF_FFF9);
        addWrite("andi x3", makeI(OpImm, F3And, 3, 1, 'h0F0), 3, 32'h0000_0060);
        addWrite("ori x4", makeI(OpImm, F3Or, 4, 1, 'h703), 4, 32'h0000_0767);
        addWrite("xori x5", makeI(OpImm, F3Xor, 5, 2, 'h0FF), 5, 32'hFFFF_FF06);
        addWrite("slti x6 neg", makeI(OpImm, F3Slt, 6, 2, 1), 6, 32'h0000_0001);
        addWrite("slti x7", makeI(OpImm, F3Slt, 7, 1, -1), 7, 32'h0000_0000);
        addWrite("add x8", makeR(F7Base, F3Add, 8, 1, 2), 8, 32'h0000_005D);
        addWrite("sub x9", makeR(F7Sub, F3Add, 9, 2, 1), 9, 32'hFFFF_FF95);
        addWrite("and x10", makeR(F7Base, F3And, 10, 4, 5), 10, 32'h0000_0706);
        addWrite("or x11", makeR(F7Base, F3Or, 11, 3, 6), 11, 32'h0000_0061);
        addWrite("xor x12", makeR(F7Base, F3Xor, 12, 1, 4), 12, 32'h0000_0703);
        addWrite("slt x13 neg", makeR(F7Base, F3Slt, 13, 2, 1), 13, 32'h0000_0001);
        addWrite("addi x16", makeI(OpImm, F3Add, 16, 0, 20), 16, 32'h0000_0014);
        addWrite("sll x15 by 20", makeR(F7Base, F3Sll, 15, 1, 16), 15, 32'h0640_0000);
        addWrite("srl x17 by 20", makeR(F7Base, F3Srl, 17, 2, 16), 17, 32'h0000_0FFF);
        addWrite("slt x14", makeR(F7Base, F3Slt, 14, 1, 2), 14, 32'h0000_0000);
        // Dependent chain with no idle cycles
        chaining = 1'b1;
        addWrite("chain addi x20", makeI(OpImm, F3Add, 20, 0, 5), 20, 32'h0000_0005);
        addWrite("chain add x21", makeR(F7Base, F3Add, 21, 20, 20), 21, 32'h0000_000A);
        addWrite("chain sub x22", makeR(F7Sub, F3Add, 22, 21, 20), 22, 32'h0000_0005);
        addWrite("chain xor x23", makeR(F7Base, F3Xor, 23, 22, 21), 23, 32'h0000_000F);
        addWrite("chain add x20", makeR(F7Base, F3Add, 20, 23, 20), 20, 32'h0000_0014);
        addWrite("chain add x24", makeR(F7Base, F3Add, 24, 20, 20), 24, 32'h0000_0028);
        addWrite("chain addi x24 a", makeI(OpImm, F3Add, 24, 24, 1), 24, 32'h0000_0029);
        chaining = 1'b0;
        addWrite("chain addi x24 b", makeI(OpImm, F3Add, 24, 24, 2), 24, 32'h0000_002B);
        addWrite("addi x25 base", makeI(OpImm, F3Add, 25, 0, 'h40), 25, 32'h0000_0040);
        addStore("sw x15 0", makeS(15, 25, 0));
        addStore("sw x9 8", makeS(9, 25, 8));
        addStore("sw x12 -4", makeS(12, 25, -4));
        addWrite("lw x26 0", makeI(OpLoad, F3Word, 26, 25, 0), 26, 32'h0640_0000);
        addWrite("lw x27 8", makeI(OpLoad, F3Word, 27, 25, 8), 27, 32'hFFFF_FF95);
        addWrite("lw x28 -4", makeI(OpLoad, F3Word, 28, 25, -4), 28, 32'h0000_0703);
        addWrite("add x29 loads", makeR(F7Base, F3Add, 29, 26, 27), 29, 32'h063F_FF95);
        addBranch("beq taken", makeB(F3Beq, 16, 20, 16), 1'b1, 16);
        addBranch("beq not taken", makeB(F3Beq, 1, 2, 8), 1'b0, 8);
        addBranch("bne taken back", makeB(F3Bne, 1, 2, -32), 1'b1, -32);
        addBranch("bne not taken", makeB(F3Bne, 16, 20, 12), 1'b0, 12);
        addBranch("blt taken signed", makeB(F3Blt, 2, 1, 20), 1'b1, 20);
        addBranch("blt not taken", makeB(F3Blt, 1, 2, 20), 1'b0, 20);
        addBranch("bge taken back", makeB(F3Bge, 1, 2, -8), 1'b1, -8);
        addBranch("bge not taken", makeB(F3Bge, 2, 1, 64), 1'b0, 64);
        addBranch("bge equal", makeB(F3Bge, 16, 20, 4), 1'b1, 4);
        chaining = 1'b1;
        addWrite("addi x0", makeI(OpImm, F3Add, 0, 1, 55), 0, 32'h0000_009B);
        chaining = 1'b0;
        addWrite("add x30 from x0", makeR(F7Base, F3Add, 30, 0, 1), 30, 32'h0000_0064);
        addIllegal("opcode 7f", makeI(7'b1111111, F3Add, 0, 0, 0));
        addIllegal("bad funct7", makeR(F7Sub, F3And, 30, 1, 2));
        addWrite("add x31 after illegal", makeR(F7Base, F3Add, 31, 30, 0), 31, 32'h0000_0064);
    endtask

    task automatic abortRun(string reason);
        $display("%s", reason);
        $display("Checks failed");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic checkIllegal(string name, logic expected);
        if (retireIllegal !== expected) begin
            abortRun($sformatf("MISMATCH %s retireIllegal expected %b actual %b",
                               name, expected, retireIllegal));
        end
    endtask

    task automatic checkWb(string name, logic expEn, regIndex_t expAddr, word_t expVal);
        if (wbEnable !== expEn) begin
            abortRun($sformatf("MISMATCH %s wbEnable expected %b actual %b",
                               name, expEn, wbEnable));
        end else if (expEn && wbAddr !== expAddr) begin
            abortRun($sformatf("MISMATCH %s wbAddr expected %0d actual %0d",
                               name, expAddr, wbAddr));
        end else if (expEn && wbData !== expVal) begin
            abortRun($sformatf("MISMATCH %s wbData expected %h actual %h",
                               name, expVal, wbData));
        end
    endtask

    task automatic checkBranch(string name, logic expValid, logic expTk, word_t expTgt);
        if (branchValid !== expValid) begin
            abortRun($sformatf("MISMATCH %s branchValid expected %b actual %b",
                               name, expValid, branchValid));
        end else if (expValid && branchTaken !== expTk) begin
            abortRun($sformatf("MISMATCH %s branchTaken expected %b actual %b",
                               name, expTk, branchTaken));
        end else if (expValid && branchTarget !== expTgt) begin
            abortRun($sformatf("MISMATCH %s branchTarget expected %h actual %h",
                               name, expTgt, branchTarget));
        end
    endtask

    task automatic issueTable();
        int gap;
        for (int i = 0; i < numEntries; i++) begin
            instrValid <= 1'b1;
            instr      <= instrs[i];
            pc         <= pcs[i];
            pending.push_back(i);
            @(posedge clk);
            gap = noGapAfter[i] ? 0 : int'($urandom % 3);
            if (gap > 0) begin
                instrValid <= 1'b0;
                repeat (gap) @(posedge clk);
            end
        end
        instrValid <= 1'b0;
    endtask

    // Retirement outputs are sampled on the falling edge
    task automatic watchRetirements();
        int waited;
        int idx;
        for (int n = 0; n < numEntries; n++) begin
            waited = 0;
            @(negedge clk);
            while (retireValid !== 1'b1) begin
                if (waited == RetireTimeout) begin
                    abortRun($sformatf("No retirement within %0d cycles for entry %0d",
                                       RetireTimeout, n));
                end
                waited++;
                @(negedge clk);
            end
            if (pending.size() == 0) begin
                abortRun("An instruction retired with nothing left to expect");
            end
            idx = pending.pop_front();
            checkIllegal(names[idx], expIllegal[idx]);
            checkWb(names[idx], expWbEn[idx], expRd[idx], expData[idx]);
            checkBranch(names[idx], expBranch[idx], expTaken[idx], expTarget[idx]);
        end
    endtask

    initial begin
        void'($urandom(39));
        reset       = 1'b1;
        instrValid  = 1'b0;
        instr       = '0;
        pc          = '0;
        extraRetire = 1'b0;
        buildTable();
        repeat (3) @(posedge clk);
        reset <= 1'b0;
        fork
            issueTable();
            watchRetirements();
        join
        // Nothing may retire once the table is done
        repeat (DrainCycles) begin
            @(negedge clk);
            if (retireValid !== 1'b0) begin
                extraRetire = 1'b1;
            end
        end
        if (!extraRetire) begin
            $display("All checks passed");
            $finish;
        end else begin
            abortRun("An instruction retired after the last table entry");
        end
    end

    initial begin
        repeat (RunLimit) @(posedge clk);
        abortRun("Global timeout, the run never reached its end");
    end

endmodule

// File: src.f
common/rvCorePkg.sv
decode/regFile.sv
decode/decoder.sv
execute/alu.sv
execute/executeStage.sv
result/resultStage.sv
source/rvCore.sv
verif/rvCoreTb.sv

// File: run.sh
#!/usr/bin/env bash
# Build the testbench with Verilator, then run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f src.f --top-module rvCoreTb -o rvCoreSim
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit $status
fi

./obj_dir/rvCoreSim
status=$?
if [ $status -ne 0 ]; then
    echo "Simulation failed with status $status"
    exit $status
fi

echo "Simulation finished with status 0"
exit 0
